/* spi_macros.svh */
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Flash window, reads here become XIP sequences
`define FLASH_ADDR_START 32'h3000_0000
`define FLASH_ADDR_END   32'h3FFF_FFFF

// SPI master register window
`define SPI_BASE 32'h1000_1000
`define SPI_END  32'h1000_1FFF

// Slave selects on the pads
`define SPI_SS_NUM 8

// Divider the sequencer programs before each flash read
`define XIP_DIVIDER 1

// Command plus one data word
`define XIP_CHAR_LEN 64

// CTRL bit positions
`define CTRL_GO_BIT 8
`define CTRL_IE_BIT 12

`endif

/* spi_core_pkg.sv */
package spi_core_pkg;

  // Register offsets, low five address bits
  // RX and TX share an offset, reads see the data register
  typedef enum logic [4:0] {
    RX0_TX0 = 5'h00,
    RX1_TX1 = 5'h04,
    CTRL    = 5'h10,
    DIVIDER = 5'h14,
    SS      = 5'h18
  } spi_reg_e;

  // Shift engine phases, SPI mode 0
  // E_LEAD  sck low, mosi holds the current bit
  // E_TRAIL sck high, miso already sampled
  // E_DONE  single cycle, done pulse
  typedef enum logic [1:0] {
    E_IDLE,
    E_LEAD,
    E_TRAIL,
    E_DONE
  } engine_state_e;

endpackage

/* xip_pkg.sv */
package xip_pkg;

  // Sequencer steps, one bus access per step except IDLE and DONE
  typedef enum logic [3:0] {
    IDLE,
    SEND_CMD,
    SET_DIVIDER,
    SET_SS,
    GO_BUSY,
    WAIT_COMPLETE,
    READ_DATA,
    CLEAR_SS,
    DONE
  } xip_state_e;

  // Serial NOR opcodes
  typedef enum logic [7:0] {
    OP_READ = 8'h03
  } flash_op_e;

endpackage

/* spi_shift_engine.sv */
`timescale 1ns/1ps

module spi_shift_engine (
  input  logic        clock,
  input  logic        reset,
  input  logic        start_i,
  input  logic [6:0]  char_len_i,
  input  logic [15:0] divider_i,
  input  logic [63:0] tx_i,
  input  logic        miso_i,
  output logic        busy_o,
  output logic        done_o,
  output logic [63:0] rx_o,
  output logic        sck_o,
  output logic        mosi_o
);

  import spi_core_pkg::*;

  engine_state_e state;
  logic [15:0]   half_cnt;
  logic          half_tick;
  logic          shifting;
  logic [6:0]    bit_len;
  logic [6:0]    bits_left;
  logic [63:0]   tx_sh;
  logic [63:0]   rx_sh;

  // Zero length means a full 64-bit word
  assign bit_len = (char_len_i == 7'd0) ? 7'd64 : char_len_i;

  // End of an SCK half-period, DIVIDER+1 clocks long
  assign half_tick = (half_cnt == 16'd0);
  assign shifting  = (state == E_LEAD) || (state == E_TRAIL);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= E_IDLE;
      sck_o     <= 1'b0;
      half_cnt  <= 16'd0;
      bits_left <= 7'd0;
    end else begin
      // Half-period counter reloads on every tick
      if (shifting) begin
        half_cnt <= half_tick ? divider_i : half_cnt - 16'd1;
      end
      case (state)
        E_IDLE: begin
          if (start_i) begin
            state     <= E_LEAD;
            half_cnt  <= divider_i;
            bits_left <= bit_len;
          end
        end
        E_LEAD: begin
          // Rising edge, miso sampled in the data block
          if (half_tick) begin
            sck_o <= 1'b1;
            state <= E_TRAIL;
          end
        end
        E_TRAIL: begin
          // Falling edge, next bit goes out
          if (half_tick) begin
            sck_o     <= 1'b0;
            bits_left <= bits_left - 7'd1;
            state     <= (bits_left == 7'd1) ? E_DONE : E_LEAD;
          end
        end
        default: state <= E_IDLE;
      endcase
    end
  end

  // Shift registers
  // tx left-aligned so the top active bit leaves first
  always_ff @(posedge clock) begin
    if ((state == E_IDLE) && start_i) begin
      tx_sh <= tx_i << (7'd64 - bit_len);
      rx_sh <= '0;
    end else if (half_tick && (state == E_LEAD)) begin
      rx_sh <= {rx_sh[62:0], miso_i};
    end else if (half_tick && (state == E_TRAIL)) begin
      tx_sh <= {tx_sh[62:0], 1'b0};
    end
  end

  // Line stays low outside a transfer
  assign mosi_o = shifting && tx_sh[63];

  // Received bits end up right-aligned
  assign rx_o   = rx_sh;
  assign busy_o = (state != E_IDLE);
  assign done_o = (state == E_DONE);

endmodule

/* spi_master_core.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_master_core #(
  parameter int ss_num = `SPI_SS_NUM
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   bus_req_i,
  input  logic                   bus_we_i,
  input  spi_core_pkg::spi_reg_e bus_adr_i,
  input  logic [31:0]            bus_wdata_i,
  output logic                   bus_ack_o,
  output logic [31:0]            bus_rdata_o,
  output logic [ss_num-1:0]      ss_o,
  output logic                   sck_o,
  output logic                   mosi_o,
  input  logic                   miso_i,
  output logic                   irq_o
);

  import spi_core_pkg::*;

  logic              access;
  logic              wr;
  logic [63:0]       data_q;
  logic [6:0]        char_len_q;
  logic              go_q;
  logic              ie_q;
  logic [15:0]       divider_q;
  logic [ss_num-1:0] ss_q;
  logic              eng_start;
  logic              eng_busy;
  logic              eng_done;
  logic [63:0]       eng_rx;
  logic [31:0]       rd_mux;

  // One access per req, on the cycle ack rises
  assign access = bus_req_i && !bus_ack_o;
  assign wr     = access && bus_we_i;

  // Four-phase ack just follows req one clock later
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      bus_ack_o <= 1'b0;
    end else begin
      bus_ack_o <= bus_req_i;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      char_len_q <= 7'd0;
      go_q       <= 1'b0;
      ie_q       <= 1'b0;
      divider_q  <= 16'd0;
      ss_q       <= '0;
      irq_o      <= 1'b0;
    end else begin
      if (eng_done) go_q <= 1'b0;
      if (wr) begin
        case (bus_adr_i)
          CTRL: begin
            char_len_q <= bus_wdata_i[6:0];
            ie_q       <= bus_wdata_i[`CTRL_IE_BIT];
            // GO_BSY only sets, the engine clears it
            if (bus_wdata_i[`CTRL_GO_BIT]) go_q <= 1'b1;
          end
          DIVIDER: divider_q <= bus_wdata_i[15:0];
          SS:      ss_q      <= bus_wdata_i[ss_num-1:0];
          default: ;
        endcase
      end
      // Any access acknowledges the interrupt, a new done wins
      if (access) irq_o <= 1'b0;
      if (eng_done && ie_q) irq_o <= 1'b1;
    end
  end

  // Transmit and receive share one data register
  always_ff @(posedge clock) begin
    if (wr && (bus_adr_i == RX0_TX0)) data_q[31:0]  <= bus_wdata_i;
    if (wr && (bus_adr_i == RX1_TX1)) data_q[63:32] <= bus_wdata_i;
    if (eng_done) data_q <= eng_rx;
  end

  always_comb begin
    rd_mux = '0;
    case (bus_adr_i)
      RX0_TX0: rd_mux = data_q[31:0];
      RX1_TX1: rd_mux = data_q[63:32];
      CTRL: begin
        rd_mux[6:0]          = char_len_q;
        rd_mux[`CTRL_GO_BIT] = go_q;
        rd_mux[`CTRL_IE_BIT] = ie_q;
      end
      DIVIDER: rd_mux = {16'd0, divider_q};
      SS:      rd_mux[ss_num-1:0] = ss_q;
      default: rd_mux = '0;
    endcase
  end

  // Read data held while ack is high
  always_ff @(posedge clock) begin
    if (access && !bus_we_i) bus_rdata_o <= rd_mux;
  end

  // Engine runs whenever GO_BSY is pending and it is idle
  assign eng_start = go_q && !eng_busy;

  // Pads are active low
  assign ss_o = ~ss_q;

  spi_shift_engine i_engine (
    .clock      (clock),
    .reset      (reset),
    .start_i    (eng_start),
    .char_len_i (char_len_q),
    .divider_i  (divider_q),
    .tx_i       (data_q),
    .miso_i     (miso_i),
    .busy_o     (eng_busy),
    .done_o     (eng_done),
    .rx_o       (eng_rx),
    .sck_o      (sck_o),
    .mosi_o     (mosi_o)
  );

endmodule

/* xip_flash_sequencer.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"

module xip_flash_sequencer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   start_i,
  input  logic [23:0]            flash_addr_i,
  input  logic                   apb_penable_i,
  output logic                   bus_req_o,
  output logic                   bus_we_o,
  output spi_core_pkg::spi_reg_e bus_adr_o,
  output logic [31:0]            bus_wdata_o,
  input  logic                   bus_ack_i,
  input  logic [31:0]            bus_rdata_i,
  output logic                   active_o,
  output logic                   done_o,
  output logic [31:0]            rdata_o
);

  import spi_core_pkg::*;
  import xip_pkg::*;

  xip_state_e state;
  xip_state_e next_state;
  // req dropped, ack still to fall
  logic       wait_low;
  // GO_BSY seen on the last CTRL poll
  logic       busy_seen;

  // Register access of each step
  // Address is held by the APB master for the whole access
  always_comb begin
    bus_we_o    = 1'b1;
    bus_adr_o   = RX0_TX0;
    bus_wdata_o = '0;
    case (state)
      SEND_CMD: begin
        // Command goes in the upper word, shifted out first
        bus_adr_o   = RX1_TX1;
        bus_wdata_o = {OP_READ, flash_addr_i};
      end
      SET_DIVIDER: begin
        bus_adr_o   = DIVIDER;
        bus_wdata_o = 32'(`XIP_DIVIDER);
      end
      SET_SS: begin
        bus_adr_o   = SS;
        bus_wdata_o = 32'd1;
      end
      GO_BUSY: begin
        // IE stays clear for XIP
        bus_adr_o   = CTRL;
        bus_wdata_o = (32'd1 << `CTRL_GO_BIT) | 32'(`XIP_CHAR_LEN);
      end
      WAIT_COMPLETE: begin
        bus_we_o  = 1'b0;
        bus_adr_o = CTRL;
      end
      READ_DATA: begin
        // Data word arrives after the command, so it sits in RX0
        bus_we_o  = 1'b0;
        bus_adr_o = RX0_TX0;
      end
      CLEAR_SS: begin
        bus_adr_o   = SS;
        bus_wdata_o = 32'd0;
      end
      default: bus_we_o = 1'b0;
    endcase
  end

  always_comb begin
    case (state)
      SEND_CMD:      next_state = SET_DIVIDER;
      SET_DIVIDER:   next_state = SET_SS;
      SET_SS:        next_state = GO_BUSY;
      GO_BUSY:       next_state = WAIT_COMPLETE;
      WAIT_COMPLETE: next_state = busy_seen ? WAIT_COMPLETE : READ_DATA;
      READ_DATA:     next_state = CLEAR_SS;
      CLEAR_SS:      next_state = DONE;
      default:       next_state = IDLE;
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state     <= IDLE;
      bus_req_o <= 1'b0;
      wait_low  <= 1'b0;
      busy_seen <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start_i) state <= SEND_CMD;
        end
        DONE: begin
          // Hold the answer until the APB master ends the access
          if (!apb_penable_i) state <= IDLE;
        end
        default: begin
          // Four-phase: raise req, see ack, drop req, see ack fall
          if (bus_req_o) begin
            if (bus_ack_i) begin
              bus_req_o <= 1'b0;
              wait_low  <= 1'b1;
              busy_seen <= bus_rdata_i[`CTRL_GO_BIT];
            end
          end else if (wait_low) begin
            if (!bus_ack_i) begin
              wait_low <= 1'b0;
              state    <= next_state;
            end
          end else if (!bus_ack_i) begin
            bus_req_o <= 1'b1;
          end
        end
      endcase
    end
  end

  // Flash word captured on the RX0 read
  always_ff @(posedge clock) begin
    if ((state == READ_DATA) && bus_req_o && bus_ack_i) rdata_o <= bus_rdata_i;
  end

  assign active_o = (state != IDLE);
  assign done_o   = (state == DONE);

endmodule

/* spi_top_apb.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"

module spi_top_apb (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [31:0]            in_paddr_i,
  input  logic                   in_psel_i,
  input  logic                   in_penable_i,
  input  logic                   in_pwrite_i,
  input  logic [31:0]            in_pwdata_i,
  output logic                   in_pready_o,
  output logic [31:0]            in_prdata_o,
  output logic                   in_pslverr_o,
  output logic                   spi_sck_o,
  output logic [`SPI_SS_NUM-1:0] spi_ss_o,
  output logic                   spi_mosi_o,
  input  logic                   spi_miso_i,
  output logic                   spi_irq_o
);

  import spi_core_pkg::*;

  logic        flash_win;
  logic        reg_win;
  logic        apb_phase;
  logic        apb_req;
  logic        apb_done;
  logic        bad_access;
  logic        err_q;
  logic        seq_req;
  logic        seq_we;
  spi_reg_e    seq_adr;
  logic [31:0] seq_wdata;
  logic        seq_active;
  logic        seq_done;
  logic [31:0] seq_rdata;
  logic        bus_req;
  logic        bus_we;
  spi_reg_e    bus_adr;
  logic [31:0] bus_wdata;
  logic        bus_ack;
  logic [31:0] bus_rdata;

  // Address decode
  assign flash_win = (in_paddr_i >= `FLASH_ADDR_START) && (in_paddr_i <= `FLASH_ADDR_END);
  assign reg_win   = (in_paddr_i >= `SPI_BASE) && (in_paddr_i <= `SPI_END);
  assign apb_phase = in_psel_i && in_penable_i;

  // Unmapped address or flash write
  assign bad_access = apb_phase && ((!flash_win && !reg_win) || (flash_win && in_pwrite_i));

  // APB side req stops once the access has been acknowledged
  assign apb_req = apb_phase && reg_win && !apb_done;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      apb_done <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      // Both flags clear in the setup phase of the next access
      apb_done <= in_penable_i && (apb_done || (apb_phase && reg_win && bus_ack));
      err_q    <= bad_access;
    end
  end

  // Sequencer owns the bus whenever it is busy
  assign bus_req   = seq_active ? seq_req : apb_req;
  assign bus_we    = seq_active ? seq_we : in_pwrite_i;
  assign bus_adr   = seq_active ? seq_adr : spi_reg_e'(in_paddr_i[4:0]);
  assign bus_wdata = seq_active ? seq_wdata : in_pwdata_i;

  // pready held high until penable falls
  assign in_pready_o  = apb_phase && (err_q || seq_done || (reg_win && (bus_ack || apb_done)));
  assign in_pslverr_o = apb_phase && err_q;
  assign in_prdata_o  = flash_win ? seq_rdata : bus_rdata;

  xip_flash_sequencer i_xip (
    .clock         (clock),
    .reset         (reset),
    .start_i       (apb_phase && flash_win && !in_pwrite_i),
    .flash_addr_i  (in_paddr_i[23:0]),
    .apb_penable_i (in_penable_i),
    .bus_req_o     (seq_req),
    .bus_we_o      (seq_we),
    .bus_adr_o     (seq_adr),
    .bus_wdata_o   (seq_wdata),
    .bus_ack_i     (bus_ack),
    .bus_rdata_i   (bus_rdata),
    .active_o      (seq_active),
    .done_o        (seq_done),
    .rdata_o       (seq_rdata)
  );

  spi_master_core #(
    .ss_num (`SPI_SS_NUM)
  ) i_core (
    .clock       (clock),
    .reset       (reset),
    .bus_req_i   (bus_req),
    .bus_we_i    (bus_we),
    .bus_adr_i   (bus_adr),
    .bus_wdata_i (bus_wdata),
    .bus_ack_o   (bus_ack),
    .bus_rdata_o (bus_rdata),
    .ss_o        (spi_ss_o),
    .sck_o       (spi_sck_o),
    .mosi_o      (spi_mosi_o),
    .miso_i      (spi_miso_i),
    .irq_o       (spi_irq_o)
  );

endmodule

/* flash_model.sv */
`timescale 1ns/1ps

module flash_model (
  input  logic sck_i,
  input  logic cs_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  // Opcode in [31:24], start address in [23:0]
  logic [31:0] cmd_q;
  int          cmd_bits;
  int          out_bits;
  logic [23:0] byte_addr;
  logic [7:0]  out_byte;

  // Image content, mixes both low address bytes
  function automatic logic [7:0] content_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5A;
  endfunction

  // Command phase
  // Mode 0, mosi sampled on rising SCK
  always @(posedge sck_i or posedge cs_n_i) begin
    if (cs_n_i) begin
      cmd_bits <= 0;
    end else if (cmd_bits < 32) begin
      cmd_q    <= {cmd_q[30:0], mosi_i};
      cmd_bits <= cmd_bits + 1;
    end
  end

  // Byte on its way out, address counts upward
  assign byte_addr = cmd_q[23:0] + 24'(out_bits / 8);
  assign out_byte  = content_byte(byte_addr);

  // Data phase
  // Next bit set up on falling SCK, MSB first
  always @(negedge sck_i or posedge cs_n_i) begin
    if (cs_n_i) begin
      out_bits <= 0;
      miso_o   <= 1'b0;
    end else if ((cmd_bits == 32) && (cmd_q[31:24] == 8'h03)) begin
      miso_o   <= out_byte[7 - (out_bits % 8)];
      out_bits <= out_bits + 1;
    end
  end

endmodule

/* tb_spi_top_apb.sv */
`timescale 1ns/1ps
`include "spi_macros.svh"

module tb_spi_top_apb;

  import spi_core_pkg::*;

  localparam int CLK_PERIOD  = 8;
  localparam int XIP_READS   = 8;
  localparam int WAIT_LIMIT  = 2000;
  // One XIP read is 64 bits at two half-periods each plus bus overhead
  localparam int XIP_READ_NS = (2 * `XIP_CHAR_LEN * (`XIP_DIVIDER + 1) + 100) * CLK_PERIOD;
  // Twenty reads with a threefold margin and some slack
  localparam int WATCHDOG_NS = 20 * XIP_READ_NS * 3 + 30000;

  logic                   clock;
  logic                   reset;
  logic [31:0]            paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [31:0]            pwdata;
  logic                   pready;
  logic [31:0]            prdata;
  logic                   pslverr;
  logic                   sck;
  logic [`SPI_SS_NUM-1:0] ss_n;
  logic                   mosi;
  logic                   miso;
  logic                   flash_miso;
  logic                   irq;
  logic                   xip_busy;
  int                     errors;
  int                     edge_errors;
  int                     prop_errors;
  int                     sck_rises;

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  spi_top_apb i_dut (
    .clock        (clock),
    .reset        (reset),
    .in_paddr_i   (paddr),
    .in_psel_i    (psel),
    .in_penable_i (penable),
    .in_pwrite_i  (pwrite),
    .in_pwdata_i  (pwdata),
    .in_pready_o  (pready),
    .in_prdata_o  (prdata),
    .in_pslverr_o (pslverr),
    .spi_sck_o    (sck),
    .spi_ss_o     (ss_n),
    .spi_mosi_o   (mosi),
    .spi_miso_i   (miso),
    .spi_irq_o    (irq)
  );

  flash_model i_flash (
    .sck_i  (sck),
    .cs_n_i (ss_n[0]),
    .mosi_i (mosi),
    .miso_o (flash_miso)
  );

  // Slave 0 is the flash model
  // Other slaves loop MOSI back
  assign miso = ss_n[0] ? mosi : flash_miso;

  // Rising SCK edges are counted
  // Flash select must be active on every edge of an XIP read
  always @(posedge sck) begin
    sck_rises++;
    if (xip_busy) begin
      assert (!ss_n[0]) else begin
        $display("Flash select was inactive on an SCK edge of an XIP read");
        edge_errors++;
      end
    end
  end

  // Error response comes with pready
  assert property (@(posedge clock) disable iff (reset) pslverr |-> pready)
    else begin
      $display("pslverr was high without pready");
      prop_errors++;
    end

  // Completed access keeps pready until penable falls
  assert property (@(posedge clock) disable iff (reset)
                   (pready && penable) |=> (pready || !penable))
    else begin
      $display("pready dropped while penable was still high");
      prop_errors++;
    end

  // Flash released before the XIP answer
  assert property (@(posedge clock) disable iff (reset)
                   (pready && penable && (paddr >= `FLASH_ADDR_START) &&
                    (paddr <= `FLASH_ADDR_END)) |-> ss_n[0])
    else begin
      $display("Flash select still active when the XIP read completed");
      prop_errors++;
    end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
    $display("Errors: %0d checks, %0d SCK, %0d protocol", errors, edge_errors, prop_errors);
    $display("Finished with errors");
    $finish;
  end

  // Byte at address a of the flash image
  function automatic logic [7:0] image_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5A;
  endfunction

  // Four bytes from a upward with the first byte most significant
  function automatic logic [31:0] image_word(input logic [23:0] a);
    return {image_byte(a), image_byte(a + 24'd1), image_byte(a + 24'd2), image_byte(a + 24'd3)};
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  // One APB transfer
  // penable dropped after a random wait once pready is seen
  task automatic apb_access(input logic [31:0] addr, input logic write, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited;
    int hold;
    hold  = int'($urandom_range(4, 0));
    rdata = '0;
    err   = 1'b0;
    @(negedge clock);
    paddr  = addr;
    pwrite = write;
    pwdata = wdata;
    psel   = 1'b1;
    @(negedge clock);
    penable = 1'b1;
    waited  = 0;
    @(negedge clock);
    while (!pready && (waited < WAIT_LIMIT)) begin
      @(negedge clock);
      waited++;
    end
    if (!pready) begin
      $display("APB access to %h never completed", addr);
      errors++;
    end else begin
      rdata = prdata;
      err   = pslverr;
      repeat (hold) begin
        @(negedge clock);
        compare_value("in_pready_o", 32'(pready), 32'd1);
      end
    end
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input spi_reg_e reg_off, input logic [31:0] data);
    logic [31:0] ignored;
    logic        err;
    apb_access(`SPI_BASE + 32'(reg_off), 1'b1, data, ignored, err);
    compare_value("in_pslverr_o", 32'(err), 32'd0);
  endtask

  task automatic apb_read(input spi_reg_e reg_off, output logic [31:0] data);
    logic err;
    apb_access(`SPI_BASE + 32'(reg_off), 1'b0, 32'd0, data, err);
    compare_value("in_pslverr_o", 32'(err), 32'd0);
  endtask

  // Poll CTRL until the engine has finished
  task automatic wait_go_clear();
    logic [31:0] ctrl;
    int          polls;
    ctrl  = 32'hFFFF_FFFF;
    polls = 0;
    while (ctrl[`CTRL_GO_BIT] && (polls < WAIT_LIMIT)) begin
      apb_read(CTRL, ctrl);
      polls++;
    end
    if (ctrl[`CTRL_GO_BIT]) begin
      $display("GO_BSY never cleared after %0d polls", polls);
      errors++;
    end
  endtask

  task automatic verify_reset_state();
    compare_value("spi_ss_o", 32'(ss_n), 32'({`SPI_SS_NUM{1'b1}}));
    compare_value("spi_sck_o", 32'(sck), 32'd0);
    compare_value("spi_mosi_o", 32'(mosi), 32'd0);
    compare_value("in_pready_o", 32'(pready), 32'd0);
    compare_value("in_pslverr_o", 32'(pslverr), 32'd0);
    compare_value("spi_irq_o", 32'(irq), 32'd0);
  endtask

  task automatic readback_registers();
    logic [31:0]            value;
    logic [31:0]            rdata;
    logic [`SPI_SS_NUM-1:0] ss_expect;
    value = {16'd0, 16'($urandom)};
    apb_write(DIVIDER, value);
    apb_read(DIVIDER, rdata);
    compare_value("DIVIDER", rdata, value);
    value = {24'd0, 8'($urandom)};
    apb_write(SS, value);
    apb_read(SS, rdata);
    compare_value("SS", rdata, value);
    // Pads are the inverse of the register
    ss_expect = ~value[`SPI_SS_NUM-1:0];
    compare_value("spi_ss_o", 32'(ss_n), 32'(ss_expect));
    value = $urandom;
    apb_write(RX0_TX0, value);
    apb_read(RX0_TX0, rdata);
    compare_value("TX0", rdata, value);
  endtask

  // Slave 1 selected so MISO is looped back from MOSI
  task automatic loopback_transfer();
    logic [31:0] tx_byte;
    logic [31:0] rdata;
    tx_byte = {24'd0, 8'($urandom)};
    apb_write(SS, 32'h2);
    apb_write(DIVIDER, 32'd2);
    apb_write(RX0_TX0, tx_byte);
    apb_write(CTRL, (32'd1 << `CTRL_GO_BIT) | 32'd8);
    wait_go_clear();
    apb_read(RX0_TX0, rdata);
    compare_value("RX0[7:0]", {24'd0, rdata[7:0]}, tx_byte);
  endtask

  task automatic interrupt_cycle();
    logic [31:0] rdata;
    int          waited;
    apb_write(CTRL, (32'd1 << `CTRL_IE_BIT) | (32'd1 << `CTRL_GO_BIT) | 32'd8);
    waited = 0;
    while (!irq && (waited < WAIT_LIMIT)) begin
      @(negedge clock);
      waited++;
    end
    compare_value("spi_irq_o", 32'(irq), 32'd1);
    // Any register access acknowledges it
    apb_read(CTRL, rdata);
    compare_value("CTRL GO_BSY", 32'(rdata[`CTRL_GO_BIT]), 32'd0);
    compare_value("spi_irq_o", 32'(irq), 32'd0);
  endtask

  task automatic flash_reads();
    logic [31:0] addr;
    logic [31:0] rdata;
    logic        err;
    int          edges;
    repeat (XIP_READS) begin
      addr     = `FLASH_ADDR_START | ($urandom & 32'h0FFF_FFFF);
      edges    = sck_rises;
      xip_busy = 1'b1;
      apb_access(addr, 1'b0, 32'd0, rdata, err);
      xip_busy = 1'b0;
      compare_value("in_prdata_o", rdata, image_word(addr[23:0]));
      compare_value("in_pslverr_o", 32'(err), 32'd0);
      // Command and data word together
      compare_value("SCK rising edges", 32'(sck_rises - edges), 32'd64);
    end
  endtask

  // Unmapped read and flash write without serial traffic
  task automatic error_responses();
    logic [31:0] rdata;
    logic        err;
    int          edges;
    edges = sck_rises;
    apb_access(32'h2000_0000 | ($urandom & 32'h00FF_FFFF), 1'b0, 32'd0, rdata, err);
    compare_value("in_pslverr_o", 32'(err), 32'd1);
    apb_access(`FLASH_ADDR_START + 32'h100, 1'b1, $urandom, rdata, err);
    compare_value("in_pslverr_o", 32'(err), 32'd1);
    compare_value("SCK rising edges", 32'(sck_rises - edges), 32'd0);
  endtask

  initial begin
    void'($urandom(32'h385234d9));
    reset     = 1'b1;
    xip_busy  = 1'b0;
    paddr     = 32'd0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = 32'd0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    verify_reset_state();
    readback_registers();
    loopback_transfer();
    interrupt_cycle();
    flash_reads();
    error_responses();
    repeat (4) @(negedge clock);
    $display("Errors: %0d checks, %0d SCK, %0d protocol", errors, edge_errors, prop_errors);
    if ((errors + edge_errors + prop_errors) == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
spi_core_pkg.sv
xip_pkg.sv
spi_shift_engine.sv
spi_master_core.sv
xip_flash_sequencer.sv
spi_top_apb.sv
flash_model.sv
tb_spi_top_apb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_spi_top_apb -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^Finished with no errors$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
